// ==== lc3_cfg.svh ====
`ifndef LC3_CFG_SVH
`define LC3_CFG_SVH

// Data and address width
`define LC3_WORD 16

// General purpose registers
`define LC3_NREG 8

// First fetch address after reset
`define LC3_RESET_PC 16'h3000

`endif

// ==== lc3IsaPkg.sv ====
package lc3IsaPkg;

	// Instruction field widths
	localparam int opcodeW = 4;
	localparam int regIdxW = 3;
	localparam int nzpW = 3;
	localparam int imm5W = 5;
	localparam int off6W = 6;
	localparam int off9W = 9;

	// Supported opcodes, other codes are skipped
	typedef enum logic [opcodeW-1:0] {
		OpBr   = 4'b0000,
		OpAdd  = 4'b0001,
		OpAnd  = 4'b0101,
		OpLdr  = 4'b0110,
		OpStr  = 4'b0111,
		OpNot  = 4'b1001,
		OpTrap = 4'b1111
	} opcodeT;

endpackage

// ==== lc3CtrlPkg.sv ====
`include "lc3_cfg.svh"

package lc3CtrlPkg;

	typedef enum logic [4:0] {
		Halted,
		Fetch,
		FetchWait,
		Decode,
		ExecAlu,
		AddrCalc,
		LoadReq,
		LoadWait,
		LoadWb,
		StoreReq,
		Branch
	} stateT;

	typedef enum logic [1:0] {
		AluAdd,
		AluAnd,
		AluNot,
		AluPassA
	} aluOpT;

	// PC and address adder select codes
	localparam logic [1:0] PcInc = 2'd0;
	localparam logic [1:0] PcBus = 2'd1;
	localparam logic [1:0] PcAdder = 2'd2;
	localparam logic [1:0] Addr2Zero = 2'd0;
	localparam logic [1:0] Addr2Off6 = 2'd1;
	localparam logic [1:0] Addr2Off9 = 2'd2;

	typedef struct packed {
		logic ldMar;
		logic ldMdr;
		logic ldIr;
		logic ldPc;
		logic ldReg;
		logic ldCc;
		logic ldBen;
		logic gatePc;
		logic gateMdr;
		logic gateAlu;
		logic gateMarMux;
		logic [1:0] pcMux;
		logic drMux;
		logic sr1Mux;
		logic sr2Mux;
		logic addr1Mux;
		logic [1:0] addr2Mux;
		aluOpT aluOp;
	} ctrlT;

	typedef struct packed {
		logic [`LC3_WORD-1:0] addr;
		logic [`LC3_WORD-1:0] wdata;
		logic write;
	} memReqT;

endpackage

// ==== lc3Control.sv ====
`timescale 1ns/1ps

module lc3Control (
	input  logic              Clk,
	input  logic              arstN,
	input  logic              run,
	input  lc3IsaPkg::opcodeT opcode,
	input  logic              irBit5,
	input  logic              ben,
	input  logic              memReqReady,
	input  logic              memRspValid,
	output lc3CtrlPkg::ctrlT  ctrl,
	output logic              memReqValid,
	output logic              memWrite,
	output logic              halted
);

	lc3CtrlPkg::stateT state;
	lc3CtrlPkg::stateT stateNext;
	logic benReg;

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= lc3CtrlPkg::Halted;
			benReg <= 1'b0;
		end
		else
		begin
			state <= stateNext;
			if (ctrl.ldBen)
				benReg <= ben;
		end
	end

	always_comb
	begin
		stateNext = state;
		ctrl = '0;
		memReqValid = 1'b0;
		memWrite = 1'b0;

		case (state)
			lc3CtrlPkg::Halted :
				if (run)
					stateNext = lc3CtrlPkg::Fetch;

			// PC drives the request address while it waits
			lc3CtrlPkg::Fetch :
			begin
				memReqValid = 1'b1;
				ctrl.gatePc = 1'b1;
				ctrl.pcMux = lc3CtrlPkg::PcInc;
				if (memReqReady)
				begin
					ctrl.ldPc = 1'b1;
					stateNext = lc3CtrlPkg::FetchWait;
				end
			end

			lc3CtrlPkg::FetchWait :
				if (memRspValid)
				begin
					ctrl.ldIr = 1'b1;
					stateNext = lc3CtrlPkg::Decode;
				end

			lc3CtrlPkg::Decode :
			begin
				ctrl.ldBen = 1'b1;
				case (opcode)
					lc3IsaPkg::OpAdd, lc3IsaPkg::OpAnd, lc3IsaPkg::OpNot :
						stateNext = lc3CtrlPkg::ExecAlu;
					lc3IsaPkg::OpLdr, lc3IsaPkg::OpStr :
						stateNext = lc3CtrlPkg::AddrCalc;
					lc3IsaPkg::OpBr :
						stateNext = lc3CtrlPkg::Branch;
					lc3IsaPkg::OpTrap :
						stateNext = lc3CtrlPkg::Halted;
					default :
						stateNext = lc3CtrlPkg::Fetch;
				endcase
			end

			lc3CtrlPkg::ExecAlu :
			begin
				ctrl.sr1Mux = 1'b1;
				ctrl.sr2Mux = irBit5;
				case (opcode)
					lc3IsaPkg::OpAnd :
						ctrl.aluOp = lc3CtrlPkg::AluAnd;
					lc3IsaPkg::OpNot :
						ctrl.aluOp = lc3CtrlPkg::AluNot;
					default :
						ctrl.aluOp = lc3CtrlPkg::AluAdd;
				endcase
				ctrl.gateAlu = 1'b1;
				ctrl.ldReg = 1'b1;
				ctrl.ldCc = 1'b1;
				stateNext = lc3CtrlPkg::Fetch;
			end

			// BaseR + offset6 into MAR, STR also moves SR into MDR
			lc3CtrlPkg::AddrCalc :
			begin
				ctrl.addr1Mux = 1'b1;
				ctrl.addr2Mux = lc3CtrlPkg::Addr2Off6;
				ctrl.ldMar = 1'b1;
				if (opcode == lc3IsaPkg::OpStr)
				begin
					ctrl.aluOp = lc3CtrlPkg::AluPassA;
					ctrl.gateAlu = 1'b1;
					ctrl.ldMdr = 1'b1;
					stateNext = lc3CtrlPkg::StoreReq;
				end
				else
					stateNext = lc3CtrlPkg::LoadReq;
			end

			lc3CtrlPkg::LoadReq :
			begin
				memReqValid = 1'b1;
				if (memReqReady)
					stateNext = lc3CtrlPkg::LoadWait;
			end

			lc3CtrlPkg::LoadWait :
				if (memRspValid)
				begin
					ctrl.ldMdr = 1'b1;
					stateNext = lc3CtrlPkg::LoadWb;
				end

			lc3CtrlPkg::LoadWb :
			begin
				ctrl.gateMdr = 1'b1;
				ctrl.ldReg = 1'b1;
				ctrl.ldCc = 1'b1;
				stateNext = lc3CtrlPkg::Fetch;
			end

			lc3CtrlPkg::StoreReq :
			begin
				memReqValid = 1'b1;
				memWrite = 1'b1;
				if (memReqReady)
					stateNext = lc3CtrlPkg::Fetch;
			end

			// PC + offset9 over the bus, taken only when ben was set in Decode
			lc3CtrlPkg::Branch :
			begin
				ctrl.addr2Mux = lc3CtrlPkg::Addr2Off9;
				ctrl.gateMarMux = 1'b1;
				ctrl.pcMux = lc3CtrlPkg::PcBus;
				ctrl.ldPc = benReg;
				stateNext = lc3CtrlPkg::Fetch;
			end

			default :
				stateNext = lc3CtrlPkg::Halted;
		endcase
	end

	assign halted = (state == lc3CtrlPkg::Halted);

endmodule

// ==== lc3Datapath.sv ====
`timescale 1ns/1ps
`include "lc3_cfg.svh"

module lc3Datapath (
	input  logic                 Clk,
	input  logic                 arstN,
	input  lc3CtrlPkg::ctrlT     ctrl,
	input  logic                 memWrite,
	input  logic [`LC3_WORD-1:0] sr1Data,
	input  logic [`LC3_WORD-1:0] sr2Data,
	input  logic [`LC3_WORD-1:0] memRspData,
	input  logic                 memRspValid,
	output logic [`LC3_WORD-1:0] ir,
	output logic [`LC3_WORD-1:0] bus,
	output lc3CtrlPkg::memReqT   memReq
);

	logic [`LC3_WORD-1:0] pc;
	logic [`LC3_WORD-1:0] pcNext;
	logic [`LC3_WORD-1:0] mar;
	logic [`LC3_WORD-1:0] mdr;
	logic [`LC3_WORD-1:0] imm5Ext;
	logic [`LC3_WORD-1:0] off6Ext;
	logic [`LC3_WORD-1:0] off9Ext;
	logic [`LC3_WORD-1:0] aluB;
	logic [`LC3_WORD-1:0] aluOut;
	logic [`LC3_WORD-1:0] addr1;
	logic [`LC3_WORD-1:0] addr2;
	logic [`LC3_WORD-1:0] addrSum;

	assign imm5Ext = {{(`LC3_WORD-lc3IsaPkg::imm5W){ir[lc3IsaPkg::imm5W-1]}},
		ir[lc3IsaPkg::imm5W-1:0]};
	assign off6Ext = {{(`LC3_WORD-lc3IsaPkg::off6W){ir[lc3IsaPkg::off6W-1]}},
		ir[lc3IsaPkg::off6W-1:0]};
	assign off9Ext = {{(`LC3_WORD-lc3IsaPkg::off9W){ir[lc3IsaPkg::off9W-1]}},
		ir[lc3IsaPkg::off9W-1:0]};

	// ALU
	assign aluB = ctrl.sr2Mux ? imm5Ext : sr2Data;

	always_comb
	begin
		unique case (ctrl.aluOp)
			lc3CtrlPkg::AluAdd :
				aluOut = sr1Data + aluB;
			lc3CtrlPkg::AluAnd :
				aluOut = sr1Data & aluB;
			lc3CtrlPkg::AluNot :
				aluOut = ~sr1Data;
			default :
				aluOut = sr1Data;
		endcase
	end

	// Base register arrives on the second read port
	assign addr1 = ctrl.addr1Mux ? sr2Data : pc;

	always_comb
	begin
		case (ctrl.addr2Mux)
			lc3CtrlPkg::Addr2Off6 :
				addr2 = off6Ext;
			lc3CtrlPkg::Addr2Off9 :
				addr2 = off9Ext;
			lc3CtrlPkg::Addr2Zero :
				addr2 = '0;
			default :
				addr2 = '0;
		endcase
	end

	assign addrSum = addr1 + addr2;

	always_comb
	begin
		if (ctrl.gatePc)
			bus = pc;
		else if (ctrl.gateMdr)
			bus = mdr;
		else if (ctrl.gateAlu)
			bus = aluOut;
		else if (ctrl.gateMarMux)
			bus = addrSum;
		else
			bus = '0;
	end

	always_comb
	begin
		case (ctrl.pcMux)
			lc3CtrlPkg::PcBus :
				pcNext = bus;
			default :
				pcNext = pc + 1'b1;
		endcase
	end

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			pc <= `LC3_RESET_PC;
			ir <= '0;
		end
		else
		begin
			if (ctrl.ldPc)
				pc <= pcNext;
			if (ctrl.ldIr)
				ir <= memRspData;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (ctrl.ldMar)
			mar <= addrSum;
		if (ctrl.ldMdr)
			mdr <= memRspValid ? memRspData : bus;
	end

	// Fetches address the PC directly while loads and stores use MAR
	always_comb
	begin
		memReq.addr = ctrl.gatePc ? pc : mar;
		memReq.wdata = mdr;
		memReq.write = memWrite;
	end

endmodule

// ==== lc3RegResult.sv ====
`timescale 1ns/1ps
`include "lc3_cfg.svh"

module lc3RegResult (
	input  logic                 Clk,
	input  logic                 arstN,
	input  lc3CtrlPkg::ctrlT     ctrl,
	input  logic [`LC3_WORD-1:0] ir,
	input  logic [`LC3_WORD-1:0] bus,
	output logic [`LC3_WORD-1:0] sr1Data,
	output logic [`LC3_WORD-1:0] sr2Data,
	output logic                 ben
);

	logic [`LC3_WORD-1:0] regs [`LC3_NREG];
	logic [lc3IsaPkg::regIdxW-1:0] drIdx;
	logic [lc3IsaPkg::regIdxW-1:0] sr1Idx;
	logic [lc3IsaPkg::regIdxW-1:0] sr2Idx;
	logic [lc3IsaPkg::nzpW-1:0] cc;
	logic busNeg;
	logic busZero;

	assign drIdx = ir[11:9];
	assign sr1Idx = ctrl.sr1Mux ? ir[8:6] : ir[11:9];
	// Second port reads BaseR during address calculation
	assign sr2Idx = ctrl.addr1Mux ? ir[8:6] : ir[2:0];

	assign sr1Data = regs[sr1Idx];
	assign sr2Data = regs[sr2Idx];

	always_ff @(posedge Clk)
	begin
		if (ctrl.ldReg)
			regs[drIdx] <= bus;
	end

	assign busNeg = bus[`LC3_WORD-1];
	assign busZero = (bus == '0);

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
			cc <= 3'b010;
		else if (ctrl.ldCc)
			cc <= {busNeg, busZero, !busNeg && !busZero};
	end

	assign ben = |(ir[11:9] & cc);

endmodule

// ==== lc3Core.sv ====
`timescale 1ns/1ps
`include "lc3_cfg.svh"

module lc3Core (
	input  logic                 Clk,
	input  logic                 arstN,
	input  logic                 run,
	output logic                 memReqValid,
	input  logic                 memReqReady,
	output lc3CtrlPkg::memReqT   memReq,
	input  logic                 memRspValid,
	input  logic [`LC3_WORD-1:0] memRspData,
	output logic                 halted
);

	lc3CtrlPkg::ctrlT ctrl;
	logic memWrite;
	logic ben;
	logic [`LC3_WORD-1:0] ir;
	logic [`LC3_WORD-1:0] bus;
	logic [`LC3_WORD-1:0] sr1Data;
	logic [`LC3_WORD-1:0] sr2Data;

	lc3Control control_i (
		.Clk(Clk),
		.arstN(arstN),
		.run(run),
		.opcode(lc3IsaPkg::opcodeT'(ir[15:12])),
		.irBit5(ir[5]),
		.ben(ben),
		.memReqReady(memReqReady),
		.memRspValid(memRspValid),
		.ctrl(ctrl),
		.memReqValid(memReqValid),
		.memWrite(memWrite),
		.halted(halted)
	);

	lc3Datapath datapath_i (
		.Clk(Clk),
		.arstN(arstN),
		.ctrl(ctrl),
		.memWrite(memWrite),
		.sr1Data(sr1Data),
		.sr2Data(sr2Data),
		.memRspData(memRspData),
		.memRspValid(memRspValid),
		.ir(ir),
		.bus(bus),
		.memReq(memReq)
	);

	lc3RegResult result_i (
		.Clk(Clk),
		.arstN(arstN),
		.ctrl(ctrl),
		.ir(ir),
		.bus(bus),
		.sr1Data(sr1Data),
		.sr2Data(sr2Data),
		.ben(ben)
	);

endmodule

// ==== lc3Core_assert.sv ====
`timescale 1ns/1ps

module lc3Core_assert (
	input logic               Clk,
	input logic               arstN,
	input logic               run,
	input logic               memReqValid,
	input logic               memReqReady,
	input lc3CtrlPkg::memReqT memReq,
	input logic               memRspValid,
	input logic               halted
);

	logic readPending;
	bit resetFail;
	bit idleFail;
	bit haltFail;
	bit stableFail;
	bit readFail;
	logic anyFail;

	// One read may be in flight until its response
	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
			readPending <= 1'b0;
		else if (memReqValid && memReqReady && !memReq.write)
			readPending <= 1'b1;
		else if (memRspValid)
			readPending <= 1'b0;
	end

	resetState : assert property (@(posedge Clk) $rose(arstN) |-> halted && !memReqValid)
		else
		begin
			$error("core not halted and idle after reset");
			resetFail = 1'b1;
		end

	idleHold : assert property (@(posedge Clk) disable iff (!arstN)
		halted && !run |=> halted)
		else
		begin
			$error("core left halted without run");
			idleFail = 1'b1;
		end

	haltQuiet : assert property (@(posedge Clk) disable iff (!arstN)
		halted |-> !memReqValid)
		else
		begin
			$error("memory request while halted");
			haltFail = 1'b1;
		end

	reqStable : assert property (@(posedge Clk) disable iff (!arstN)
		memReqValid && !memReqReady |=> memReqValid && $stable(memReq))
		else
		begin
			$error("memory request changed under back-pressure");
			stableFail = 1'b1;
		end

	singleRead : assert property (@(posedge Clk) disable iff (!arstN)
		readPending |-> !(memReqValid && !memReq.write))
		else
		begin
			$error("second read issued before the response");
			readFail = 1'b1;
		end

	assign anyFail = resetFail | idleFail | haltFail | stableFail | readFail;

endmodule

// ==== lc3Tb.sv ====
`timescale 1ns/1ps
`include "lc3_cfg.svh"

module lc3Tb;

	localparam logic [`LC3_WORD-1:0] dataAddr = 16'h0010;
	localparam logic [`LC3_WORD-1:0] dataWord = 16'h8005;

	logic Clk = 1'b0;
	logic arstN;
	logic run;
	logic memReqValid;
	logic memReqReady;
	lc3CtrlPkg::memReqT memReq;
	logic memRspValid;
	logic [`LC3_WORD-1:0] memRspData;
	logic halted;

	logic [`LC3_WORD-1:0] mem [0:65535];
	logic [`LC3_WORD-1:0] refMem [0:65535];
	lc3CtrlPkg::memReqT expStores [$];
	int storeIdx = 0;

	always #50 Clk = ~Clk;

	lc3Core dut_i (
		.Clk(Clk),
		.arstN(arstN),
		.run(run),
		.memReqValid(memReqValid),
		.memReqReady(memReqReady),
		.memReq(memReq),
		.memRspValid(memRspValid),
		.memRspData(memRspData),
		.halted(halted)
	);

	bind lc3Core lc3Core_assert assert_i (
		.Clk(Clk),
		.arstN(arstN),
		.run(run),
		.memReqValid(memReqValid),
		.memReqReady(memReqReady),
		.memReq(memReq),
		.memRspValid(memRspValid),
		.halted(halted)
	);

	task automatic abortRun();
		$display("test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] state);
		logic [31:0] s;
		s = state;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// Instruction encoders
	function automatic logic [15:0] aluImm(input lc3IsaPkg::opcodeT op, input int dr,
		input int sr1, input int imm);
		return {op, dr[2:0], sr1[2:0], 1'b1, imm[4:0]};
	endfunction

	function automatic logic [15:0] aluReg(input lc3IsaPkg::opcodeT op, input int dr,
		input int sr1, input int sr2);
		return {op, dr[2:0], sr1[2:0], 3'b000, sr2[2:0]};
	endfunction

	function automatic logic [15:0] notReg(input int dr, input int sr);
		return {lc3IsaPkg::OpNot, dr[2:0], sr[2:0], 6'b111111};
	endfunction

	function automatic logic [15:0] memOp(input lc3IsaPkg::opcodeT op, input int r,
		input int base, input int off);
		return {op, r[2:0], base[2:0], off[5:0]};
	endfunction

	function automatic logic [15:0] branch(input logic [2:0] nzp, input int off);
		return {lc3IsaPkg::OpBr, nzp, off[8:0]};
	endfunction

	// Program image at the reset PC plus one data word
	function automatic logic [15:0] imageWord(input logic [15:0] addr);
		logic [15:0] word;
		case (addr - `LC3_RESET_PC)
			16'd0  : word = aluImm(lc3IsaPkg::OpAnd, 6, 6, 0);
			16'd1  : word = memOp(lc3IsaPkg::OpLdr, 1, 6, 16);
			16'd2  : word = memOp(lc3IsaPkg::OpStr, 1, 6, 0);
			16'd3  : word = aluImm(lc3IsaPkg::OpAdd, 2, 1, 3);
			16'd4  : word = memOp(lc3IsaPkg::OpStr, 2, 6, 1);
			16'd5  : word = aluImm(lc3IsaPkg::OpAnd, 3, 3, 0);
			16'd6  : word = aluImm(lc3IsaPkg::OpAdd, 3, 3, -7);
			16'd7  : word = aluReg(lc3IsaPkg::OpAdd, 4, 1, 3);
			16'd8  : word = memOp(lc3IsaPkg::OpStr, 4, 6, 2);
			16'd9  : word = aluReg(lc3IsaPkg::OpAnd, 5, 4, 2);
			16'd10 : word = memOp(lc3IsaPkg::OpStr, 5, 6, 3);
			16'd11 : word = notReg(0, 5);
			16'd12 : word = memOp(lc3IsaPkg::OpStr, 0, 6, 4);
			16'd13 : word = aluImm(lc3IsaPkg::OpAnd, 7, 1, 12);
			16'd14 : word = memOp(lc3IsaPkg::OpStr, 7, 6, 5);
			16'd15 : word = branch(3'b100, 1);
			16'd16 : word = memOp(lc3IsaPkg::OpStr, 7, 6, 6);
			16'd17 : word = branch(3'b001, 1);
			16'd18 : word = memOp(lc3IsaPkg::OpStr, 1, 6, 7);
			16'd19 : word = aluImm(lc3IsaPkg::OpAnd, 2, 2, 0);
			16'd20 : word = branch(3'b010, 1);
			16'd21 : word = memOp(lc3IsaPkg::OpStr, 2, 6, 8);
			16'd22 : word = branch(3'b101, 1);
			16'd23 : word = memOp(lc3IsaPkg::OpStr, 0, 6, 9);
			16'd24 : word = notReg(3, 3);
			16'd25 : word = aluImm(lc3IsaPkg::OpAdd, 3, 3, -16);
			16'd26 : word = branch(3'b100, 1);
			16'd27 : word = memOp(lc3IsaPkg::OpStr, 3, 6, 10);
			16'd28 : word = memOp(lc3IsaPkg::OpLdr, 5, 6, 3);
			16'd29 : word = aluReg(lc3IsaPkg::OpAdd, 5, 5, 3);
			16'd30 : word = memOp(lc3IsaPkg::OpStr, 5, 6, 11);
			// Reserved opcode that the core skips
			16'd31 : word = 16'hD000;
			16'd32 : word = aluImm(lc3IsaPkg::OpAnd, 4, 4, 0);
			16'd33 : word = aluImm(lc3IsaPkg::OpAdd, 4, 4, 3);
			16'd34 : word = memOp(lc3IsaPkg::OpStr, 4, 6, 12);
			16'd35 : word = aluImm(lc3IsaPkg::OpAdd, 6, 6, 1);
			16'd36 : word = aluImm(lc3IsaPkg::OpAdd, 4, 4, -1);
			16'd37 : word = branch(3'b001, -4);
			16'd38 : word = {lc3IsaPkg::OpTrap, 12'h025};
			default :
				word = (addr == dataAddr) ? dataWord
					: addr ^ {addr[7:0], addr[15:8]} ^ 16'h5A3C;
		endcase
		return word;
	endfunction

	function automatic logic [15:0] signExtend(input logic [15:0] value, input int width);
		logic signed [15:0] shifted;
		shifted = value << (16 - width);
		return shifted >>> (16 - width);
	endfunction

	function automatic logic [2:0] condCodes(input logic [15:0] value);
		return {value[15], value == 16'd0, !value[15] && value != 16'd0};
	endfunction

	// Instruction level model that collects every store in order
	task automatic buildExpected();
		logic [15:0] regs [8];
		logic [15:0] pc;
		logic [15:0] ins;
		logic [15:0] opB;
		logic [15:0] result;
		logic [15:0] addr;
		logic [2:0] cc;
		logic done;
		int steps;
		int i;
		lc3CtrlPkg::memReqT store;
		for (i = 0; i < 8; i++)
			regs[i] = 16'd0;
		pc = `LC3_RESET_PC;
		cc = 3'b010;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 2000)
		begin
			ins = refMem[pc];
			pc = pc + 16'd1;
			steps++;
			case (ins[15:12])
				lc3IsaPkg::OpAdd, lc3IsaPkg::OpAnd, lc3IsaPkg::OpNot :
				begin
					opB = ins[5] ? signExtend(ins, 5) : regs[ins[2:0]];
					if (ins[15:12] == lc3IsaPkg::OpAdd)
						result = regs[ins[8:6]] + opB;
					else if (ins[15:12] == lc3IsaPkg::OpAnd)
						result = regs[ins[8:6]] & opB;
					else
						result = ~regs[ins[8:6]];
					regs[ins[11:9]] = result;
					cc = condCodes(result);
				end
				lc3IsaPkg::OpLdr :
				begin
					addr = regs[ins[8:6]] + signExtend(ins, 6);
					regs[ins[11:9]] = refMem[addr];
					cc = condCodes(refMem[addr]);
				end
				lc3IsaPkg::OpStr :
				begin
					addr = regs[ins[8:6]] + signExtend(ins, 6);
					refMem[addr] = regs[ins[11:9]];
					store.addr = addr;
					store.wdata = regs[ins[11:9]];
					store.write = 1'b1;
					expStores.push_back(store);
				end
				lc3IsaPkg::OpBr :
					if (|(ins[11:9] & cc))
						pc = pc + signExtend(ins, 9);
				lc3IsaPkg::OpTrap :
					done = 1'b1;
				default : ;
			endcase
		end
		if (!done)
		begin
			$display("reference model never reached the TRAP instruction");
			abortRun();
		end
	endtask

	task automatic waitForHalted(input logic level, input int limit, input string what);
		int cycles;
		cycles = 0;
		do
		begin
			@(negedge Clk);
			cycles++;
		end
		while (halted !== level && cycles < limit);
		if (halted !== level)
		begin
			$display("timeout after %0d cycles waiting for %s", cycles, what);
			abortRun();
		end
	endtask

	// Memory with random ready and a 0 to 3 cycle read latency
	initial
	begin : memoryModel
		logic [31:0] rng;
		logic rspPending;
		int rspWait;
		logic [15:0] rspAddr;
		lc3CtrlPkg::memReqT expected;
		int a;
		for (a = 0; a < 65536; a++)
			mem[a] = imageWord(a[15:0]);
		rng = 32'd13;
		rspPending = 1'b0;
		rspWait = 0;
		rspAddr = '0;
		memReqReady = 1'b0;
		memRspValid = 1'b0;
		memRspData = '0;
		forever
		begin
			@(posedge Clk);
			memRspValid <= 1'b0;
			if (rspPending)
			begin
				if (rspWait == 0)
				begin
					memRspValid <= 1'b1;
					memRspData <= mem[rspAddr];
					rspPending = 1'b0;
				end
				else
					rspWait = rspWait - 1;
			end
			if (memReqValid && memReqReady)
			begin
				if (memReq.write)
				begin
					assert (storeIdx < expStores.size())
					else
					begin
						$display("store to %h at %0t was not expected", memReq.addr, $time);
						abortRun();
					end
					expected = expStores[storeIdx];
					assert (memReq.addr == expected.addr)
					else
					begin
						$display("mismatch at %0t: memReq.addr got %h expected %h",
							$time, memReq.addr, expected.addr);
						abortRun();
					end
					assert (memReq.wdata == expected.wdata)
					else
					begin
						$display("mismatch at %0t: memReq.wdata got %h expected %h",
							$time, memReq.wdata, expected.wdata);
						abortRun();
					end
					storeIdx++;
					mem[memReq.addr] = memReq.wdata;
				end
				else
				begin
					rspPending = 1'b1;
					rspAddr = memReq.addr;
					rng = xorshift(rng);
					rspWait = int'(rng[1:0]);
				end
			end
			rng = xorshift(rng);
			memReqReady <= (rng[3:2] != 2'b00);
		end
	end

	always @(negedge Clk)
	begin
		if (dut_i.assert_i.anyFail)
		begin
			$display("bound protocol assertion failed at %0t", $time);
			abortRun();
		end
	end

	initial
	begin : stimulus
		int a;
		arstN = 1'b0;
		run = 1'b0;
		for (a = 0; a < 65536; a++)
			refMem[a] = imageWord(a[15:0]);
		buildExpected();
		repeat (16) @(posedge Clk);
		arstN <= 1'b1;
		// Idle with Run low first
		repeat (4) @(posedge Clk);
		run <= 1'b1;
		waitForHalted(1'b0, 10, "the core to start after run");
		@(posedge Clk);
		run <= 1'b0;
		waitForHalted(1'b1, 5000, "TRAP to halt the core");
		repeat (8) @(posedge Clk);
		// Let the assertions of the last edge settle
		@(negedge Clk);
		if (storeIdx == expStores.size() && halted && !dut_i.assert_i.anyFail)
		begin
			$display("test passed");
			$finish;
		end
		else
		begin
			$display("core stopped after %0d of %0d expected stores", storeIdx,
				expStores.size());
			abortRun();
		end
	end

endmodule

// ==== files.f ====
+incdir+.
lc3IsaPkg.sv
lc3CtrlPkg.sv
lc3Control.sv
lc3Datapath.sv
lc3RegResult.sv
lc3Core.sv
lc3Core_assert.sv
lc3Tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module lc3Tb -o lc3Tb

# Assertion errors must not stop the run before the testbench reports them
out=$(./obj_dir/lc3Tb +verilator+error+limit+100 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "test passed"; then
	exit 0
fi
exit 1
